/* nand_pkg.sv */
/* Shared types and constants for the NAND probe.
   Imported by the sequencer, FIFO, UART and top level. */
package nand_pkg;

    // Raw NAND pins as driven by the probe
    typedef struct packed {
        logic       ce_n;
        logic       cle;
        logic       ale;
        logic       we_n;
        logic       re_n;
        logic       oe;     // Drive dout onto the IO lines
        logic [7:0] dout;
    } nand_bus_t;

    typedef enum logic [2:0] {
        OP_CMD,
        OP_ADDR,
        OP_READ,
        OP_WAIT,
        OP_END
    } step_op_t;

    typedef struct packed {
        step_op_t   op;
        logic [7:0] data;
    } step_t;

    localparam int PHASE_CYCLES    = 4;    // Clocks per bus phase
    localparam int STEP_PHASES     = 4;    // Setup, strobe low, strobe high, hold
    localparam int UART_DIV        = 8;    // Clocks per UART bit
    localparam int FIFO_DEPTH      = 16;
    localparam int N_READ_BYTES    = 10;
    localparam int SCRIPT_LEN      = 18;   // Script entries including OP_END
    localparam int UART_FRAME_BITS = 10;   // Start, 8 data, stop

    localparam int CYC_W      = $clog2(PHASE_CYCLES);
    localparam int PHASE_W    = $clog2(STEP_PHASES);
    localparam int STEP_PTR_W = $clog2(SCRIPT_LEN);
    localparam int FIFO_AW    = $clog2(FIFO_DEPTH);
    localparam int BAUD_W     = $clog2(UART_DIV);
    localparam int BIT_CNT_W  = $clog2(UART_FRAME_BITS);
    localparam int SENT_W     = $clog2(N_READ_BYTES + 1);

    // Chip deselected, both strobes high, IO released
    localparam nand_bus_t IDLE_BUS = '{
        ce_n: 1'b1,
        cle:  1'b0,
        ale:  1'b0,
        we_n: 1'b1,
        re_n: 1'b1,
        oe:   1'b0,
        dout: 8'hFF
    };

endpackage

/* nand_sequencer.sv */
`timescale 1ns/1ps
/* Steps through the fixed NAND probe script after start and drives the bus phase by phase.
   Read bytes come out on rd_byte with a one-cycle rd_valid strobe. */
module nand_sequencer (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  logic [7:0]          nand_din,
    output nand_pkg::nand_bus_t nand_bus,
    output logic [7:0]          rd_byte,
    output logic                rd_valid,
    output logic                busy
);
    import nand_pkg::*;

    typedef enum logic {
        S_IDLE,
        S_RUN
    } state_t;

    state_t                state;
    logic [CYC_W-1:0]      cyc;
    logic [PHASE_W-1:0]    phase;
    logic [STEP_PTR_W-1:0] ptr;
    step_t                 cur;
    nand_bus_t             bus_next;
    logic                  phase_last;
    logic                  step_last;
    logic                  re_rise;

    // Script ROM
    function automatic step_t script_step(input logic [STEP_PTR_W-1:0] idx);
        case (int'(idx))
            0:       return '{op: OP_CMD,  data: 8'hFF};  // RESET
            1:       return '{op: OP_WAIT, data: 8'h00};
            2:       return '{op: OP_CMD,  data: 8'h70};  // READ STATUS
            3:       return '{op: OP_READ, data: 8'h00};
            4:       return '{op: OP_CMD,  data: 8'h90};  // READ ID, ONFI signature
            5:       return '{op: OP_ADDR, data: 8'h20};
            6:       return '{op: OP_READ, data: 8'h00};
            7:       return '{op: OP_READ, data: 8'h00};
            8:       return '{op: OP_READ, data: 8'h00};
            9:       return '{op: OP_READ, data: 8'h00};
            10:      return '{op: OP_CMD,  data: 8'h90};  // READ ID, maker and device
            11:      return '{op: OP_ADDR, data: 8'h00};
            12:      return '{op: OP_READ, data: 8'h00};
            13:      return '{op: OP_READ, data: 8'h00};
            14:      return '{op: OP_READ, data: 8'h00};
            15:      return '{op: OP_READ, data: 8'h00};
            16:      return '{op: OP_READ, data: 8'h00};
            default: return '{op: OP_END,  data: 8'h00};
        endcase
    endfunction

    // Pin levels of one step in a given phase; phase 1 is the strobe-low phase
    function automatic nand_bus_t step_pins(input step_t s, input logic [PHASE_W-1:0] ph);
        nand_bus_t b;
        b = IDLE_BUS;
        case (s.op)
            OP_CMD, OP_ADDR: begin
                b.ce_n = 1'b0;
                b.cle  = (s.op == OP_CMD);
                b.ale  = (s.op == OP_ADDR);
                b.oe   = 1'b1;
                b.dout = s.data;
                b.we_n = (ph != PHASE_W'(1));
            end
            OP_READ: begin
                b.ce_n = 1'b0;
                b.re_n = (ph != PHASE_W'(1));
            end
            default: ;  // WAIT and END leave the bus idle
        endcase
        return b;
    endfunction

    assign cur        = script_step(ptr);
    assign phase_last = (cyc == CYC_W'(PHASE_CYCLES - 1));
    assign step_last  = phase_last && (phase == PHASE_W'(STEP_PHASES - 1));
    assign bus_next   = (state == S_RUN) ? step_pins(cur, phase) : IDLE_BUS;
    assign re_rise    = !nand_bus.re_n && bus_next.re_n;  // Last cycle of strobe low
    assign busy       = (state == S_RUN);

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            state    <= S_IDLE;
            cyc      <= '0;
            phase    <= '0;
            ptr      <= '0;
            nand_bus <= IDLE_BUS;
            rd_valid <= 1'b0;
        end else begin
            nand_bus <= bus_next;  // Registered so the pins do not glitch
            rd_valid <= re_rise;
            case (state)
                S_IDLE: begin
                    if (start) begin
                        state <= S_RUN;
                        cyc   <= '0;
                        phase <= '0;
                        ptr   <= '0;
                    end
                end
                S_RUN: begin
                    if (cur.op == OP_END) begin
                        state <= S_IDLE;
                    end else if (step_last) begin
                        cyc   <= '0;
                        phase <= '0;
                        ptr   <= ptr + 1'b1;
                    end else if (phase_last) begin
                        cyc   <= '0;
                        phase <= phase + 1'b1;
                    end else begin
                        cyc <= cyc + 1'b1;
                    end
                end
                default: state <= S_IDLE;
            endcase
        end
    end

    always_ff @(posedge clk) begin
        if (re_rise)
            rd_byte <= nand_din;
    end

    a_strobes_exclusive: assert property (@(posedge clk) disable iff (!arst_n)
        nand_bus.we_n || nand_bus.re_n)
        else $error("we_n and re_n low together");

endmodule

/* byte_fifo.sv */
`timescale 1ns/1ps
/* Small circular FIFO holding captured NAND bytes until the UART can send them.
   dout shows the oldest entry whenever empty is low. */
module byte_fifo (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       push,
    input  logic [7:0] din,
    input  logic       pop,
    output logic [7:0] dout,
    output logic       empty,
    output logic       full
);
    import nand_pkg::*;

    logic [7:0]         mem [FIFO_DEPTH];
    logic [FIFO_AW-1:0] wr_ptr;
    logic [FIFO_AW-1:0] rd_ptr;
    logic [FIFO_AW:0]   count;
    logic               do_push;
    logic               do_pop;

    assign empty   = (count == '0);
    assign full    = (count == (FIFO_AW + 1)'(FIFO_DEPTH));
    assign do_push = push && !full;
    assign do_pop  = pop && !empty;
    assign dout    = mem[rd_ptr];

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (do_push)
                wr_ptr <= wr_ptr + 1'b1;  // Wraps at FIFO_DEPTH
            if (do_pop)
                rd_ptr <= rd_ptr + 1'b1;
            if (do_push && !do_pop)
                count <= count + 1'b1;
            else if (do_pop && !do_push)
                count <= count - 1'b1;
        end
    end

    always_ff @(posedge clk) begin
        if (do_push)
            mem[wr_ptr] <= din;
    end

    a_no_overflow: assert property (@(posedge clk) disable iff (!arst_n) push |-> !full)
        else $error("push into full FIFO");

    a_no_underflow: assert property (@(posedge clk) disable iff (!arst_n) pop |-> !empty)
        else $error("pop from empty FIFO");

endmodule

/* uart_tx.sv */
`timescale 1ns/1ps
/* 8N1 UART transmitter, UART_DIV clocks per bit, LSB first.
   Pulse load with data while busy is low; busy falls after the stop bit. */
module uart_tx (
    input  logic       clk,
    input  logic       arst_n,
    input  logic       load,
    input  logic [7:0] data,
    output logic       txd,
    output logic       busy
);
    import nand_pkg::*;

    logic [UART_FRAME_BITS-1:0] shreg;
    logic [BAUD_W-1:0]          baud_cnt;
    logic [BIT_CNT_W-1:0]       bit_cnt;
    logic                       bit_end;

    assign bit_end = (baud_cnt == BAUD_W'(UART_DIV - 1));
    assign txd     = shreg[0];  // Straight from a flop

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            shreg    <= '1;  // Line idles high
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b0;
        end else if (load && !busy) begin
            shreg    <= {1'b1, data, 1'b0};  // Stop, data, start
            baud_cnt <= '0;
            bit_cnt  <= '0;
            busy     <= 1'b1;
        end else if (busy) begin
            if (bit_end) begin
                baud_cnt <= '0;
                shreg    <= {1'b1, shreg[UART_FRAME_BITS-1:1]};
                bit_cnt  <= bit_cnt + 1'b1;
                if (bit_cnt == BIT_CNT_W'(UART_FRAME_BITS - 1))
                    busy <= 1'b0;  // Stop bit done
            end else begin
                baud_cnt <= baud_cnt + 1'b1;
            end
        end
    end

    a_no_load_busy: assert property (@(posedge clk) disable iff (!arst_n) load |-> !busy)
        else $error("UART load while busy");

endmodule

/* nand_probe_top.sv */
`timescale 1ns/1ps
/* NAND probe top level. Runs the ID script on start and streams every byte read
   out of txd; done pulses once the last byte has left the UART. */
module nand_probe_top (
    input  logic                clk,
    input  logic                arst_n,
    input  logic                start,
    input  logic [7:0]          nand_din,
    output nand_pkg::nand_bus_t nand_bus,
    output logic                txd,
    output logic                busy,
    output logic                done
);
    import nand_pkg::*;

    logic [7:0]        rd_byte;
    logic              rd_valid;
    logic              seq_busy;
    logic              seq_start;
    logic [7:0]        fifo_dout;
    logic              fifo_empty;
    logic              fifo_full;
    logic              pop_load;
    logic              tx_busy;
    logic              tx_busy_q;
    logic [SENT_W-1:0] sent_cnt;

    assign seq_start = start && !busy;  // No new run until the last byte is out
    assign pop_load  = !fifo_empty && !tx_busy;
    assign done      = tx_busy_q && !tx_busy && (sent_cnt == SENT_W'(N_READ_BYTES));
    assign busy      = seq_busy || !fifo_empty || tx_busy || tx_busy_q;

    nand_sequencer u_seq (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (seq_start),
        .nand_din (nand_din),
        .nand_bus (nand_bus),
        .rd_byte  (rd_byte),
        .rd_valid (rd_valid),
        .busy     (seq_busy)
    );

    byte_fifo u_fifo (
        .clk    (clk),
        .arst_n (arst_n),
        .push   (rd_valid),
        .din    (rd_byte),
        .pop    (pop_load),
        .dout   (fifo_dout),
        .empty  (fifo_empty),
        .full   (fifo_full)
    );

    uart_tx u_uart (
        .clk    (clk),
        .arst_n (arst_n),
        .load   (pop_load),
        .data   (fifo_dout),
        .txd    (txd),
        .busy   (tx_busy)
    );

    always_ff @(posedge clk or negedge arst_n) begin
        if (!arst_n) begin
            tx_busy_q <= 1'b0;
            sent_cnt  <= '0;
        end else begin
            tx_busy_q <= tx_busy;
            if (done)
                sent_cnt <= '0;
            else if (pop_load)
                sent_cnt <= sent_cnt + 1'b1;
        end
    end

    // Script reads fit in the FIFO with no backpressure
    a_fifo_room: assert property (@(posedge clk) disable iff (!arst_n)
        rd_valid |-> !fifo_full)
        else $error("read byte with FIFO full");

    a_done_drained: assert property (@(posedge clk) disable iff (!arst_n)
        done |-> !seq_busy && fifo_empty)
        else $error("done with work still pending");

endmodule

/* nand_flash_model.sv */
`timescale 1ns/1ps
/* Behavioral NAND chip for the probe testbench. Logs each command and address byte
   and answers READ STATUS and READ ID from fixed tables. */
module nand_flash_model (
    input  nand_pkg::nand_bus_t bus,
    input  logic                log_clr,
    output logic [7:0]          din
);
    import nand_pkg::*;

    logic       we_n;
    logic       re_n;
    logic [7:0] last_cmd = 8'h00;
    logic [7:0] id_addr  = 8'h00;
    int         re_cnt   = 0;      // Read strobes seen so far
    int         re_mark  = 0;      // re_cnt at the last command or address
    int         log_cnt  = 0;
    logic [7:0] log_data [$];
    step_op_t   log_op [$];

    // ID space, ONFI signature at 20h and maker/device bytes at 00h
    function automatic logic [7:0] id_byte(input logic [7:0] a);
        case (a)
            8'h00:   return 8'h2C;
            8'h01:   return 8'hDC;
            8'h02:   return 8'h90;
            8'h03:   return 8'h95;
            8'h04:   return 8'h56;
            8'h20:   return 8'h4F;  // O
            8'h21:   return 8'h4E;  // N
            8'h22:   return 8'h46;  // F
            8'h23:   return 8'h49;  // I
            default: return 8'h00;
        endcase
    endfunction

    assign we_n = bus.we_n;
    assign re_n = bus.re_n;

    always_comb begin
        if (last_cmd == 8'h70)
            din = 8'hE0;  // Ready, not write protected
        else if (last_cmd == 8'h90)
            din = id_byte(id_addr + 8'(re_cnt - re_mark));
        else
            din = 8'h00;
    end

    // Next byte is presented once the strobe rises
    always @(posedge re_n) begin
        re_cnt <= re_cnt + 1;
    end

    always @(posedge we_n or posedge log_clr) begin
        if (log_clr) begin
            log_data.delete();
            log_op.delete();
            log_cnt = 0;
        end else if (bus.cle || bus.ale) begin
            log_data.push_back(bus.dout);
            log_op.push_back(bus.cle ? OP_CMD : OP_ADDR);
            log_cnt = log_cnt + 1;
            re_mark = re_cnt;
            if (bus.cle)
                last_cmd = bus.dout;
            else
                id_addr = bus.dout;
        end
    end

endmodule

/* tb_nand_probe.sv */
`timescale 1ns/1ps
/* Directed testbench for the NAND probe. Runs the ID script against a NAND model,
   decodes txd back into bytes and checks bus order, data, done and busy. */
module tb_nand_probe;
    import nand_pkg::*;

    localparam int LOG_LEN        = 6;
    localparam int RUN_CYCLES     = N_READ_BYTES * UART_FRAME_BITS * UART_DIV
                                    + SCRIPT_LEN * STEP_PHASES * PHASE_CYCLES;
    localparam int TIMEOUT_CYCLES = 6 * RUN_CYCLES;  // Four full runs, one cut short, margin

    logic       clk = 1'b0;
    logic       arst_n;
    logic       start;
    logic       log_clr;
    logic [7:0] nand_din;
    nand_bus_t  nand_bus;
    logic       txd;
    logic       busy;
    logic       done;
    int         cycle_cnt = 0;
    int         done_seen;
    bit         extra_starts = 1'b0;
    logic [7:0] rx_bytes [$];

    nand_probe_top DUT (
        .clk      (clk),
        .arst_n   (arst_n),
        .start    (start),
        .nand_din (nand_din),
        .nand_bus (nand_bus),
        .txd      (txd),
        .busy     (busy),
        .done     (done)
    );

    nand_flash_model flash (
        .bus     (nand_bus),
        .log_clr (log_clr),
        .din     (nand_din)
    );

    always #20 clk = ~clk;

    always @(posedge clk) begin
        cycle_cnt <= cycle_cnt + 1;
        if (cycle_cnt == TIMEOUT_CYCLES) begin
            $display("Timeout: tests did not finish within %0d cycles", TIMEOUT_CYCLES);
            $display("TEST FAIL");
            $fatal(1, "simulation stopped by watchdog");
        end
    end

    function automatic logic [7:0] expected_byte(input int n);
        case (n)
            0:       return 8'hE0;  // Status
            1:       return 8'h4F;  // ONFI
            2:       return 8'h4E;
            3:       return 8'h46;
            4:       return 8'h49;
            5:       return 8'h2C;  // Maker
            6:       return 8'hDC;  // Device
            7:       return 8'h90;
            8:       return 8'h95;
            default: return 8'h56;
        endcase
    endfunction

    function automatic logic [7:0] expected_log_byte(input int n);
        case (n)
            0:       return 8'hFF;
            1:       return 8'h70;
            2:       return 8'h90;
            3:       return 8'h20;
            4:       return 8'h90;
            default: return 8'h00;
        endcase
    endfunction

    function automatic step_op_t expected_log_op(input int n);
        if (n == 3 || n == 5)
            return OP_ADDR;
        return OP_CMD;
    endfunction

    task automatic check_value(input string sig, input logic [31:0] exp, input logic [31:0] got);
        assert (got === exp)
        else begin
            $display("MISMATCH t=%0t %s expected %0h got %0h", $time, sig, exp, got);
            $display("TEST FAIL");
            $fatal(1, "stopping at first error");
        end
    endtask

    // One clock: drive on the rising edge, sample on the falling edge
    task automatic tick();
        @(posedge clk);
        start   <= extra_starts && ($urandom_range(7) == 0);
        log_clr <= 1'b0;
        @(negedge clk);
        done_seen = done_seen + (done ? 1 : 0);
    endtask

    task automatic check_idle_outputs();
        check_value("nand_bus", 32'(IDLE_BUS), 32'(nand_bus));
        check_value("txd", 1, 32'(txd));
        check_value("busy", 0, 32'(busy));
        check_value("done", 0, 32'(done));
    endtask

    // Samples txd at mid-bit, LSB first
    task automatic uart_rx(output logic [7:0] b);
        b = 8'h00;
        while (txd === 1'b1)
            tick();
        repeat (UART_DIV / 2) tick();
        check_value("txd start bit", 0, 32'(txd));
        repeat (8) begin
            repeat (UART_DIV) tick();
            b = {txd, b[7:1]};
        end
        repeat (UART_DIV) tick();
        check_value("txd stop bit", 1, 32'(txd));
    endtask

    task automatic check_log();
        check_value("model log length", LOG_LEN, flash.log_cnt);
        for (int i = 0; i < LOG_LEN; i++) begin
            check_value($sformatf("model log byte %0d", i), 32'(expected_log_byte(i)),
                        32'(flash.log_data[i]));
            check_value($sformatf("model log kind %0d", i), 32'(expected_log_op(i)),
                        32'(flash.log_op[i]));
        end
    endtask

    task automatic check_bytes();
        check_value("received byte count", N_READ_BYTES, rx_bytes.size());
        for (int i = 0; i < N_READ_BYTES; i++)
            check_value($sformatf("txd byte %0d", i), 32'(expected_byte(i)), 32'(rx_bytes[i]));
    endtask

    // Full run from start to done, then a quiet window with no extra traffic
    task automatic run_script(input bit with_extra_starts);
        logic [7:0] b;
        @(posedge clk);
        log_clr <= 1'b1;
        start   <= 1'b1;
        rx_bytes.delete();
        done_seen    = 0;
        extra_starts = with_extra_starts;
        repeat (N_READ_BYTES) begin
            uart_rx(b);
            rx_bytes.push_back(b);
        end
        extra_starts = 1'b0;  // Busy stays high until after done
        check_value("done pulses before last stop bit", 0, done_seen);
        while (done_seen == 0)
            tick();
        tick();
        check_value("done", 0, 32'(done));
        check_value("busy", 0, 32'(busy));
        repeat (40) begin
            tick();
            check_idle_outputs();
        end
        check_value("done pulses per run", 1, done_seen);
        check_log();
        check_bytes();
    endtask

    task automatic test_idle_after_reset();
        repeat (20) begin
            tick();
            check_idle_outputs();
        end
    endtask

    task automatic test_single_run();
        run_script(1'b0);
    endtask

    task automatic test_start_while_busy();
        run_script(1'b1);
        run_script(1'b0);
    endtask

    task automatic test_reset_mid_run();
        int cut;
        cut = $urandom_range(400, 100);
        @(posedge clk);
        start <= 1'b1;
        repeat (cut) tick();
        @(posedge clk);
        arst_n <= 1'b0;
        start  <= 1'b0;
        @(negedge clk);
        check_idle_outputs();
        repeat (4) @(posedge clk);
        arst_n <= 1'b1;
        run_script(1'b0);
    endtask

    initial begin
        void'($urandom(32'hd032));
        arst_n  = 1'b0;
        start   = 1'b0;
        log_clr = 1'b0;
        repeat (5) @(posedge clk);
        arst_n <= 1'b1;
        test_idle_after_reset();
        test_single_run();
        test_start_while_busy();
        test_reset_mid_run();
        $display("TEST PASS");
        $finish;
    end

endmodule

/* nand_probe.f */
nand_pkg.sv
nand_sequencer.sv
byte_fifo.sv
uart_tx.sv
nand_probe_top.sv
nand_flash_model.sv
tb_nand_probe.sv

/* run_sim.sh */
#!/bin/sh
# Compile and run the NAND probe testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --assert -j 0 \
    --top-module tb_nand_probe \
    -f nand_probe.f \
    -o sim_nand_probe

./obj_dir/sim_nand_probe | tee sim.log

if grep -q "TEST PASS" sim.log; then
    echo "Simulation passed"
else
    echo "Simulation failed, see sim.log"
    exit 1
fi
